// File: Bender.yml
package:
  name: sha_rig

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/sha_pkg.sv
      - hdl/rig_pkg.sv
      - hdl/press_decoder.sv
      - hdl/hash_sequencer.sv
      - hdl/block_builder.sv
      - hdl/sha256_core.sv
      - hdl/op_stats.sv
      - hdl/sha_rig_top.sv
  - target: test
    include_dirs:
      - hdl
      - bench
    files:
      - bench/tb_sha_rig.sv

// File: all.f
+incdir+hdl
+incdir+bench
hdl/sha_pkg.sv
hdl/rig_pkg.sv
hdl/press_decoder.sv
hdl/hash_sequencer.sv
hdl/block_builder.sv
hdl/sha256_core.sv
hdl/op_stats.sv
hdl/sha_rig_top.sv
bench/tb_sha_rig.sv

// File: bench/sha_model.svh
// Reference SHA-256 compression and message block constructors for the rig testbench
`ifndef SHA_MODEL_SVH
`define SHA_MODEL_SVH

function automatic word_t ror32(input word_t x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

//////////////////////////////////////////////////////////////////////
// One block of FIPS 180-4 compression, full 64 word schedule
//////////////////////////////////////////////////////////////////////
function automatic digest_t sha_compress(input digest_t hin, input block_t blk);
	word_t w [64];
	word_t a, b, c, d, e, f, g, h;
	word_t s0, s1, t1, t2;
	digest_t v;
	digest_t res;
	for (int t = 0; t < 16; t++) begin
		w[t] = blk[511 - 32*t -: 32]; // Word 0 on top
	end
	for (int t = 16; t < 64; t++) begin
		s0 = ror32(w[t-15], 7) ^ ror32(w[t-15], 18) ^ (w[t-15] >> 3);
		s1 = ror32(w[t-2], 17) ^ ror32(w[t-2], 19) ^ (w[t-2] >> 10);
		w[t] = s1 + w[t-7] + s0 + w[t-16];
	end
	{a, b, c, d, e, f, g, h} = hin;
	for (int t = 0; t < 64; t++) begin
		t1 = h + (ror32(e, 6) ^ ror32(e, 11) ^ ror32(e, 25)) + ((e & f) ^ (~e & g)) +
			SHA_K[t] + w[t];
		t2 = (ror32(a, 2) ^ ror32(a, 13) ^ ror32(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
		h = g;
		g = f;
		f = e;
		e = d + t1;
		d = c;
		c = b;
		b = a;
		a = t1 + t2;
	end
	v = {a, b, c, d, e, f, g, h};
	for (int i = 0; i < 8; i++) begin
		res[255 - 32*i -: 32] = hin[255 - 32*i -: 32] + v[255 - 32*i -: 32]; // Chaining add
	end
	return res;
endfunction

// 56 text bytes, then the 0x80 pad byte, rest zero
function automatic block_t first_block();
	string msg;
	block_t blk;
	msg = "abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq";
	blk = '0;
	for (int i = 0; i < 56; i++) begin
		blk[511 - 8*i -: 8] = msg[i];
	end
	blk[511 - 8*56 -: 8] = 8'h80;
	return blk;
endfunction

// Nonce word, fourteen zero words, length word
function automatic block_t nonce_block(input word_t nonce);
	return {nonce, 448'h0, 32'(`RIG_BLOCK1_LENGTH)};
endfunction

`endif

// File: bench/tb_sha_rig.sv
// Testbench for the SHA-256 rig, random button presses checked against a hash model
`timescale 1ns/100ps
`default_nettype none

`include "rig_cfg.svh"

module tb_sha_rig import sha_pkg::*, rig_pkg::*; ();

	localparam int unsigned seed = 13049;
	localparam int n_short = 3;  // Extra single presses
	localparam int n_cont = 36;  // Digests taken from the long press run
	localparam int quiet_len = 300;
	localparam int gap_min = `RIG_RELEASE_CYCLES + 151;
	localparam int gap_max = `RIG_RELEASE_CYCLES + 250;
	localparam int digest_wait = `RIG_LONG_CYCLES + 4 * `RIG_ROUNDS;
	localparam int short_span = `RIG_LONG_CYCLES + digest_wait + gap_max;

	// Sum of all test lengths plus margin
	localparam longint cycle_limit = 2 + 52 +
		(`RIG_RELEASE_CYCLES + 240 + `RIG_PRESS_CYCLES) +
		(1 + n_short) * short_span +
		(`RIG_LONG_CYCLES + 60) + (n_cont + 8) * `RIG_ROUNDS +
		(2 * `RIG_ROUNDS + 10) + `RIG_LONG_CYCLES + 2 * quiet_len + digest_wait +
		2000;

	logic clk;
	logic reset;
	logic fire_button;
	digest_t digest;
	logic digest_valid;
	op_total_t op_total;
	op_rate_t op_rate;

	int unsigned lcg_state = seed;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	longint cycle_count = 0;
	digest_t got_q [$];     // Every digest seen, in order
	longint stamp_q [$];    // Cycle of each digest
	digest_t midstate_exp;  // Model result of block 0
	int unsigned next_nonce = 0;
	int checked = 0;        // Digests already compared

	`include "sha_model.svh"

	initial clk = 1'b0;
	always #5 clk = ~clk; // 10 ns period

	sha_rig_top u_sha_rig_top (
		.clk          (clk),
		.reset        (reset),
		.fire_button  (fire_button),
		.digest       (digest),
		.digest_valid (digest_valid),
		.op_total     (op_total),
		.op_rate      (op_rate)
	);

	//////////////////////////////////////////////////////////////////////
	// Monitor, cycle counter and run limit
	//////////////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		if (digest_valid === 1'b1) begin // Mid cycle, outputs settled
			got_q.push_back(digest);
			stamp_q.push_back(cycle_count);
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////
	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 8; // Drop weak low bits
	endfunction

	function automatic int rand_between(input int lo, input int hi);
		return lo + int'(lcg_next() % (hi - lo + 1));
	endfunction

	task automatic check_value(input logic [255:0] got, input logic [255:0] expected,
		input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error at %0t: %s, got %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// Button high for hold cycles, then low
	task automatic push_button(input int hold);
		@(posedge clk);
		fire_button <= 1'b1;
		repeat (hold) @(posedge clk);
		fire_button <= 1'b0;
	endtask

	task automatic wait_digests(input int target, input int limit);
		int waited;
		waited = 0;
		while (got_q.size() < target && waited < limit) begin
			@(posedge clk);
			waited++;
		end
		if (got_q.size() < target) begin
			errors++;
			$display("waited %0d cycles for digest %0d but only %0d arrived",
				limit, target, got_q.size());
		end
	endtask

	// Returns once no digest has come for quiet cycles
	task automatic wait_quiet(input int quiet, input int limit);
		int waited;
		int run;
		int last;
		waited = 0;
		run = 0;
		last = got_q.size();
		while (run < quiet && waited < limit) begin
			@(posedge clk);
			waited++;
			if (got_q.size() != last) begin
				last = got_q.size();
				run = 0;
			end else begin
				run++;
			end
		end
		if (run < quiet) begin
			errors++;
			$display("digests kept coming after the stop press");
		end
	endtask

	// Compare new digests against consecutive nonces
	task automatic check_new_digests();
		while (checked < got_q.size()) begin
			check_value(got_q[checked], sha_compress(midstate_exp, nonce_block(next_nonce)),
				$sformatf("digest for nonce %0d", next_nonce));
			checked++;
			next_nonce++;
		end
	endtask

	task automatic check_total();
		@(negedge clk);
		check_value(op_total, got_q.size(), "op_total against digests seen");
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		int e0;
		int n0;
		int base;
		reset = 1'b1;
		fire_button = 1'b0;
		midstate_exp = sha_compress(SHA_H0, first_block());
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// Quiet after reset
		e0 = errors;
		idle_cycles(50);
		@(negedge clk);
		check_value(got_q.size(), 0, "digests after reset");
		check_value(op_total, 0, "op_total after reset");
		check_value(op_rate, 0, "op_rate after reset");
		check_value(digest, 0, "digest after reset");
		finish_test("reset state", e0);

		// Glitch ignored, then one press gives nonce 0
		e0 = errors;
		push_button(rand_between(2, `RIG_PRESS_CYCLES - 6));
		idle_cycles(`RIG_RELEASE_CYCLES + 240);
		check_value(got_q.size(), 0, "digests after glitch");
		push_button(rand_between(`RIG_PRESS_CYCLES + 5, `RIG_LONG_CYCLES - 20));
		wait_digests(1, digest_wait);
		idle_cycles(rand_between(gap_min, gap_max));
		check_value(got_q.size(), 1, "digests after first press");
		check_new_digests();
		check_total();
		finish_test("glitch and first press", e0);

		// Each short press adds one digest
		e0 = errors;
		for (int p = 0; p < n_short; p++) begin
			n0 = got_q.size();
			push_button(rand_between(`RIG_PRESS_CYCLES + 5, `RIG_LONG_CYCLES - 20));
			wait_digests(n0 + 1, digest_wait);
			idle_cycles(rand_between(gap_min, gap_max));
			check_value(got_q.size(), n0 + 1, "digests after short press");
			check_new_digests();
			check_total();
		end
		finish_test("short presses", e0);

		// Long press, continuous run
		e0 = errors;
		base = got_q.size();
		push_button(`RIG_LONG_CYCLES + 60);
		wait_digests(base + n_cont, (n_cont + 8) * `RIG_ROUNDS + `RIG_LONG_CYCLES);
		check_new_digests();
		for (int i = base + 2; i < got_q.size(); i++) begin // First gap includes restart
			check_value(stamp_q[i] - stamp_q[i-1], `RIG_ROUNDS, "digest spacing");
		end
		finish_test("continuous run", e0);

		// Window lies fully inside the run by now
		e0 = errors;
		@(negedge clk);
		check_value(op_rate == 15 || op_rate == 16, 1, "op_rate over a full window");
		finish_test("rate window", e0);

		// Stop press lands mid pass, ten cycles after a digest
		e0 = errors;
		wait_digests(got_q.size() + 1, 2 * `RIG_ROUNDS);
		idle_cycles(10);
		n0 = got_q.size();
		push_button(rand_between(`RIG_PRESS_CYCLES + 5, `RIG_LONG_CYCLES - 20));
		wait_quiet(quiet_len, quiet_len + digest_wait);
		check_value(got_q.size() - n0 <= 1, 1, "at most one digest after stop");
		check_new_digests();
		check_total();
		finish_test("stop press", e0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/block_builder.sv
// Message block assembly, constant block 0 and nonce-bearing block 1
`timescale 1ns/100ps
`default_nettype none

`include "rig_cfg.svh"

module block_builder import sha_pkg::*; (
	input  wire    clk,
	input  wire    reset,
	input  wire    load_msg,  // Snapshot nonce and advance
	input  wire    block_sel,
	output block_t block
);

	// "abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq" plus pad start
	localparam block_t block0 = {
		32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667,
		32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b,
		32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f,
		32'h6d6e6f70, 32'h6e6f7071, 32'h80000000, 32'h00000000
	};

	word_t nonce;     // Next nonce to use
	word_t msg_nonce; // Nonce held in block 1

	always_ff @(posedge clk) begin
		if (reset) begin
			nonce <= '0;
		end else if (load_msg) begin
			nonce <= nonce + 1'b1; // Full 32 bit wrap
		end
	end

	always_ff @(posedge clk) begin
		if (load_msg) begin
			msg_nonce <= nonce;
		end
	end

	// Nonce, fourteen zero words, then the length
	assign block = block_sel ? {msg_nonce, {14{32'h0}}, `RIG_BLOCK1_LENGTH} : block0;

endmodule

`default_nettype wire

// File: hdl/hash_sequencer.sv
// Hash sequencer, continuous mode latch and block schedule counter
`timescale 1ns/100ps
`default_nettype none

`include "rig_cfg.svh"

module hash_sequencer import rig_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	input  wire        press,       // Short press pulse
	input  wire        held,        // Long hold level
	output logic       load_msg,    // Capture nonce into block 1
	output logic       block_start, // Core start strobe
	output logic       block_sel,   // 0 = block 0, 1 = block 1
	output hash_mode_e mode
);

	// Schedule points
	localparam seq_count_t cnt_load = 8'd1;
	localparam seq_count_t cnt_start0 = 8'd2;
	localparam seq_count_t cnt_start1 = cnt_start0 + seq_count_t'(`RIG_ROUNDS);
	localparam seq_count_t cnt_last = cnt_start1 + seq_count_t'(`RIG_ROUNDS - 1);

	logic continuous; // Long press keeps hashing
	logic go;
	seq_count_t count;

	// Set by a long hold, cleared by the next short press
	always_ff @(posedge clk) begin
		if (reset) begin
			continuous <= 1'b0;
		end else if (held) begin
			continuous <= 1'b1;
		end else if (press) begin
			continuous <= 1'b0;
		end
	end

	assign go = press || continuous;

	//////////////////////////////////////////////////////////////////////
	// Schedule counter
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (count == '0) begin
			count <= go ? cnt_load : '0;
		end else if (count == cnt_last) begin
			count <= go ? cnt_start1 : '0; // Redo block 1 only
		end else begin
			count <= count + 1'b1;
		end
	end

	// Strobe decode
	assign load_msg = (count == cnt_load) || (count == cnt_last && go);
	assign block_start = (count == cnt_start0) || (count == cnt_start1);
	assign block_sel = (count == cnt_start1);
	assign mode = (count == cnt_start0) ? mode_init : mode_redo;

	a_load_start_excl: assert property (@(posedge clk) disable iff (reset)
		!(load_msg && block_start));

endmodule

`default_nettype wire

// File: hdl/op_stats.sv
// Digest statistics, running total and count per tick window
`timescale 1ns/100ps
`default_nettype none

`include "rig_cfg.svh"

module op_stats import rig_pkg::*; (
	input  wire       clk,
	input  wire       reset,
	input  wire       digest_valid,
	output op_total_t op_total,
	output op_rate_t  op_rate     // Digests in the last full window
);

	localparam int tick_w = $clog2(`RIG_TICK_CYCLES);

	logic [tick_w-1:0] tick_count;
	logic tick_end;
	op_rate_t win_count; // Digests so far in this window

	assign tick_end = (tick_count == tick_w'(`RIG_TICK_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			tick_count <= '0;
			win_count <= '0;
			op_total <= '0;
			op_rate <= '0;
		end else begin
			op_total <= op_total + op_total_t'(digest_valid);
			if (tick_end) begin
				tick_count <= '0;
				op_rate <= win_count + op_rate_t'(digest_valid); // Include last cycle
				win_count <= '0;
			end else begin
				tick_count <= tick_count + 1'b1;
				win_count <= win_count + op_rate_t'(digest_valid);
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/press_decoder.sv
// Push button synchronizer and debouncer giving a press pulse and a long hold level
`timescale 1ns/100ps
`default_nettype none

`include "rig_cfg.svh"

module press_decoder import rig_pkg::*; (
	input  wire  clk,
	input  wire  reset,
	input  wire  fire_button, // Raw pad, asynchronous
	output logic press,       // One cycle per accepted press
	output logic held         // Long hold until release confirmed
);

	localparam int press_w = $clog2(`RIG_LONG_CYCLES + 1);
	localparam int release_w = $clog2(`RIG_RELEASE_CYCLES + 1);

	logic [1:0] sync;
	logic btn;
	press_state_e state;
	logic [press_w-1:0] press_count;     // Time since first edge
	logic [release_w-1:0] release_count; // Time low while releasing

	// Two flop synchronizer
	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= 2'b00;
		end else begin
			sync <= {sync[0], fire_button};
		end
	end
	assign btn = sync[1];

	//////////////////////////////////////////////////////////////////////
	// Debounce FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle:       state <= btn ? wait_press : idle;
				wait_press: state <= !btn ? idle :
					(press_count == press_w'(`RIG_PRESS_CYCLES)) ? wait_pulse : wait_press;
				wait_pulse: state <= // Ignores bounce
					(press_count == press_w'(`RIG_PULSE_CYCLES)) ? wait_long : wait_pulse;
				wait_long:  state <= !btn ? wait_off :
					(press_count >= press_w'(`RIG_LONG_CYCLES)) ? long : wait_long;
				long:       state <= !btn ? wait_loff : long;
				wait_off:   state <= btn ? wait_long :
					(release_count == release_w'(`RIG_RELEASE_CYCLES)) ? idle : wait_off;
				wait_loff:  state <= btn ? long :
					(release_count == release_w'(`RIG_RELEASE_CYCLES)) ? idle : wait_loff;
				default:    state <= idle;
			endcase
		end
	end

	// Counters
	always_ff @(posedge clk) begin
		if (reset) begin
			press_count <= '0;
			release_count <= '0;
		end else begin
			if (state == idle) begin
				press_count <= '0;
			end else if (press_count != press_w'(`RIG_LONG_CYCLES)) begin
				press_count <= press_count + 1'b1; // Saturates at long threshold
			end
			release_count <= (state == wait_off || state == wait_loff) ?
				release_count + 1'b1 : '0;
		end
	end

	// Pulse on the edge into the pulse phase
	assign press = (state == wait_press) && btn &&
		(press_count == press_w'(`RIG_PRESS_CYCLES));
	assign held = (state == long) || (state == wait_loff);

	a_press_held_excl: assert property (@(posedge clk) disable iff (reset)
		!(press && held));

endmodule

`default_nettype wire

// File: hdl/rig_cfg.svh
// Timing, round count and message layout constants for the SHA-256 rig
`ifndef RIG_CFG_SVH
`define RIG_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Button timing, scaled down for simulation
//////////////////////////////////////////////////////////////////////
`define RIG_PRESS_CYCLES   20   // HW 5 ms at 48 MHz = 240000
`define RIG_PULSE_CYCLES   40   // HW 25 ms = 1200000
`define RIG_LONG_CYCLES    200  // HW about 0.7 s = 'h2000000
`define RIG_RELEASE_CYCLES 60   // HW 100 ms = 4800000

// Rate window, one second on the board
`define RIG_TICK_CYCLES    1000 // HW 48000000

//////////////////////////////////////////////////////////////////////
// Hash engine and message layout
//////////////////////////////////////////////////////////////////////
`define RIG_ROUNDS         64           // Rounds per block
`define RIG_BLOCK1_LENGTH  32'h000001C0 // Message length in bits, last word of block 1

`endif

// File: hdl/rig_pkg.sv
// Control types for the rig, button FSM, hash modes and counter widths
`default_nettype none

package rig_pkg;

	// Debounce FSM states
	typedef enum logic [2:0] {
		idle,
		wait_press, // Button seen, qualifying
		wait_pulse, // Press accepted
		wait_long,  // Still down, timing a long hold
		long,       // Long hold confirmed
		wait_off,   // Released after short press
		wait_loff   // Released after long hold
	} press_state_e;

	// Chaining source for one block
	typedef enum logic [1:0] {
		mode_init = 2'd1, // From H0, result kept as midstate
		mode_redo = 2'd3  // From midstate, result published
	} hash_mode_e;

	typedef logic [7:0]  seq_count_t;
	typedef logic [47:0] op_total_t;
	typedef logic [31:0] op_rate_t;

endpackage

`default_nettype wire

// File: hdl/sha256_core.sv
// SHA-256 compression core, one round per clock with midstate reuse
`timescale 1ns/100ps
`default_nettype none

`include "rig_cfg.svh"

module sha256_core import sha_pkg::*, rig_pkg::*; (
	input  wire             clk,
	input  wire             reset,
	input  wire             block_start, // Round 0 runs in this cycle
	input  wire hash_mode_e mode,
	input  wire block_t     block,
	output digest_t         digest,
	output logic            digest_valid
);
	localparam int round_w = $clog2(`RIG_ROUNDS);
	localparam logic [round_w-1:0] round_last = round_w'(`RIG_ROUNDS - 1);

	logic busy;
	logic [round_w-1:0] round; // Round done next edge
	hash_mode_e mode_q;
	digest_t midstate;         // Block 0 result
	digest_t work;             // a..h
	word_t sched [16];         // Sliding W window

	digest_t chain_start, chain_run;
	digest_t round_in, round_out, final_sum;
	word_t win [16];
	word_t w_new;
	word_t k_cur;
	logic last_round;

	function automatic word_t rotr(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Round datapath
	//////////////////////////////////////////////////////////////////////
	assign chain_start = (mode == mode_init) ? SHA_H0 : midstate;
	assign chain_run = (mode_q == mode_init) ? SHA_H0 : midstate; // Midstate stable in redo
	assign round_in = block_start ? chain_start : work;
	assign k_cur = SHA_K[block_start ? '0 : round];
	assign last_round = busy && (round == round_last);

	// Fresh block feeds the window directly
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			win[i] = block_start ? block[511 - 32*i -: 32] : sched[i];
		end
	end

	// W[t+16] from the window
	assign w_new = (rotr(win[14], 17) ^ rotr(win[14], 19) ^ (win[14] >> 10)) + win[9] +
		(rotr(win[1], 7) ^ rotr(win[1], 18) ^ (win[1] >> 3)) + win[0];

	always_comb begin : round_calc
		word_t a, b, c, d, e, f, g, h;
		word_t t1, t2;
		{a, b, c, d, e, f, g, h} = round_in;
		t1 = h + (rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25)) + ((e & f) ^ (~e & g)) +
			k_cur + win[0];
		t2 = (rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
		round_out = {t1 + t2, a, b, c, d + t1, e, f, g};
	end

	// Word-wise add of the chaining value
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			final_sum[32*i +: 32] = chain_run[32*i +: 32] + round_out[32*i +: 32];
		end
	end

	// Working state and schedule
	always_ff @(posedge clk) begin
		if (block_start || busy) begin
			work <= round_out;
			for (int i = 0; i < 15; i++) begin
				sched[i] <= win[i + 1];
			end
			sched[15] <= w_new;
		end
		if (last_round && mode_q == mode_init) begin
			midstate <= final_sum;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Round control and output
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			round <= '0;
			mode_q <= mode_init;
			digest <= '0;
			digest_valid <= 1'b0;
		end else begin
			digest_valid <= 1'b0;
			if (block_start) begin
				busy <= 1'b1;
				round <= round_w'(1);
				mode_q <= mode;
			end else if (busy) begin
				round <= round + 1'b1;
				if (last_round) begin
					busy <= 1'b0; // Idle from the next cycle
					if (mode_q == mode_redo) begin
						digest <= final_sum;
						digest_valid <= 1'b1;
					end
				end
			end
		end
	end

	// Sequencer must wait for the previous block to finish
	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		block_start |-> !busy);
	a_redo_latency: assert property (@(posedge clk) disable iff (reset)
		block_start && mode == mode_redo |-> ##(`RIG_ROUNDS) digest_valid);

endmodule

`default_nettype wire

// File: hdl/sha_pkg.sv
// SHA-256 word, block and state types with the standard constants
`default_nettype none

package sha_pkg;

	typedef logic [31:0]  word_t;   // One hash word
	typedef logic [511:0] block_t;  // Word 0 in bits 511:480
	typedef logic [255:0] digest_t; // a..h, a in the top word

	// FIPS 180-4 initial hash value
	localparam digest_t SHA_H0 = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	// Round constants K0..K63
	localparam word_t SHA_K [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
		32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
		32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
		32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
		32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
		32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

endpackage

`default_nettype wire

// File: hdl/sha_rig_top.sv
// SHA-256 test rig top, button control feeding the hash core and statistics
`timescale 1ns/100ps
`default_nettype none

module sha_rig_top import sha_pkg::*, rig_pkg::*; (
	input  wire       clk,
	input  wire       reset,
	input  wire       fire_button,
	output digest_t   digest,
	output logic      digest_valid,
	output op_total_t op_total,
	output op_rate_t  op_rate
);

	logic press, held;
	logic load_msg, block_start, block_sel;
	hash_mode_e mode;
	block_t block;

	//////////////////////////////////////////////////////////////////////
	// Control path
	//////////////////////////////////////////////////////////////////////
	press_decoder u_press (
		.clk         (clk),
		.reset       (reset),
		.fire_button (fire_button),
		.press       (press),
		.held        (held)
	);

	hash_sequencer u_seq (
		.clk         (clk),
		.reset       (reset),
		.press       (press),
		.held        (held),
		.load_msg    (load_msg),
		.block_start (block_start),
		.block_sel   (block_sel),
		.mode        (mode)
	);

	//////////////////////////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////////////////////////
	block_builder u_block (
		.clk       (clk),
		.reset     (reset),
		.load_msg  (load_msg),
		.block_sel (block_sel),
		.block     (block)
	);

	sha256_core u_core (
		.clk          (clk),
		.reset        (reset),
		.block_start  (block_start),
		.mode         (mode),
		.block        (block),
		.digest       (digest),
		.digest_valid (digest_valid)
	);

	op_stats u_stats (
		.clk          (clk),
		.reset        (reset),
		.digest_valid (digest_valid), // Counts redo results only
		.op_total     (op_total),
		.op_rate      (op_rate)
	);

endmodule

`default_nettype wire
